//--- Makefile
# Verilator build and run of the object line scanner testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module obj_line_scan_tb -f tb.f -o obj_line_scan_sim
	./obj_dir/obj_line_scan_sim | tee $(LOG)
	@if grep -qx "Everything OK" $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

//--- sim/obj_line_scan_chk.sv
`timescale 1ns/1ns

module obj_line_scan_chk (
    input logic clk,
    input logic rst,
    input logic ent_push,      // reader into the entry queue
    input logic ent_full,
    input logic ent_pop,       // expander out of the entry queue
    input logic ent_empty,
    input logic tile_push,     // expander into the request queue
    input logic tile_full,
    input logic pop,           // consumer out of the request queue
    input logic tile_empty,
    input logic line_done,
    input logic out_valid
);

    int fail_count = 0;        // failed assertions so far

    // ============================================================
    // queue rules
    // ============================================================
    a_ent_push : assert property (@(posedge clk) disable iff (rst) ent_push |-> !ent_full)
        else begin
            fail_count++;
            $error("entry queue pushed while full");
        end
    a_tile_push : assert property (@(posedge clk) disable iff (rst) tile_push |-> !tile_full)
        else begin
            fail_count++;
            $error("request queue pushed while full");
        end
    a_ent_pop : assert property (@(posedge clk) disable iff (rst) ent_pop |-> !ent_empty)
        else begin
            fail_count++;
            $error("entry queue popped while empty");
        end
    a_tile_pop : assert property (@(posedge clk) disable iff (rst) pop |-> !tile_empty)
        else begin
            fail_count++;
            $error("request queue popped while empty");
        end

    // ============================================================
    // strobe rules
    // ============================================================
    a_done_pulse : assert property (@(posedge clk) disable iff (rst) line_done |=> !line_done)
        else begin
            fail_count++;
            $error("line_done held for more than one cycle");
        end
    a_rst_valid : assert property (@(posedge clk) rst |-> !out_valid)
        else begin
            fail_count++;
            $error("out_valid high during reset");
        end

endmodule

//--- sim/obj_line_scan_tb.sv
`timescale 1ns/1ns

`include "obj_settings.svh"

module obj_line_scan_tb
    import obj_pkg::*;
();

    localparam int NUM_LINES = 16;                                  // four lines per phase
    localparam int LIMIT     = NUM_LINES * `OBJ_COUNT * 16 * 8 + 5000;

    logic               clk;
    logic               rst;
    logic               cen;
    logic               wr;
    logic [`OBJ_AW-1:0] addr;
    obj_entry_t         wdata;
    logic               line_start;
    logic [8:0]         vrender;
    logic               pop;
    logic               out_valid;
    obj_tile_t          out_tile;
    logic               line_done;

    obj_entry_t         mirror [`OBJ_COUNT];   // what the table should hold
    obj_tile_t          exp_q [$];             // requests still owed by the DUT
    string              test_name;
    int                 value_errs;
    int                 count_errs;
    int                 proto_errs;
    int                 cycles;
    int                 hold;                  // consumer pause, in cycles
    logic               stalls_on;
    logic               started;
    logic [8:0]         vline;
    int                 phase;
    int                 nwrite;
    logic [`OBJ_AW-1:0] wr_idx;

    obj_line_scan dut (
        .clk, .rst, .cen, .wr, .addr, .wdata, .line_start, .vrender,
        .pop, .out_valid, .out_tile, .line_done);

    bind obj_line_scan obj_line_scan_chk u_chk (
        .clk(clk), .rst(rst), .ent_push(ent_push), .ent_full(ent_full),
        .ent_pop(ent_pop), .ent_empty(ent_empty), .tile_push(tile_push),
        .tile_full(tile_full), .pop(pop), .tile_empty(tile_empty),
        .line_done(line_done), .out_valid(out_valid));

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout after %0d cycles in %s, the scan never finished",
                     cycles, test_name);
            $display("Something failed");
            $finish;
        end
    end

    // ============================================================
    // reference model
    // ============================================================
    task automatic build_expected(input logic [8:0] line);
        obj_entry_t o;
        obj_tile_t  t;
        logic [9:0] vs;
        logic [9:0] bottom;
        logic [9:0] ycross;
        logic [3:0] row;
        vs = {line[8], line};                                   // sign-extended line
        for (int i = 0; i < `OBJ_COUNT; i++) begin
            o      = mirror[i];
            bottom = o.y + 10'(16 * (int'(o.tile_m) + 1));      // 10-bit, may wrap
            ycross = vs - o.y;
            if (vs >= o.y && vs < bottom) begin
                row = o.vflip ? o.tile_m - ycross[7:4] : ycross[7:4];
                for (int c = 0; c <= int'(o.tile_n); c++) begin
                    t.code = o.code + 16'(16 * int'(row) + c);  // wraps past 0xffff
                    t.x    = o.x + 9'(16 * c);
                    t.vsub = o.vflip ? ~ycross[3:0] : ycross[3:0];
                    exp_q.push_back(t);
                end
            end
        end
    endtask

    function automatic obj_entry_t rand_entry(input logic [8:0] line, input int kind);
        obj_entry_t o;
        logic [9:0] vs;
        int         span;
        vs       = {line[8], line};
        o.code   = 16'($urandom);
        o.x      = 9'($urandom);
        o.tile_n = 4'($urandom);
        o.tile_m = 4'($urandom);
        o.vflip  = 1'($urandom);
        span     = 16 * (int'(o.tile_m) + 1) + 16;   // a bit past the object bottom
        o.y      = vs - 10'($urandom % span);        // mostly covers the line
        if (kind == 1) begin
            o.code  = 16'hffc0 + 16'($urandom % 64); // column and row sums carry out
            o.vflip = ($urandom % 4) != 0;
        end
        if (kind == 2 && ($urandom % 4) == 0) begin
            o.y = 10'h3e0 + 10'($urandom % 32);      // hangs past the top
        end
        if (($urandom % 8) == 0) begin
            o.y = 10'($urandom);                     // anywhere, mostly a miss
        end
        return o;
    endfunction

    // ============================================================
    // drivers and consumer
    // ============================================================
    task automatic take_head();
        obj_tile_t e;
        if (exp_q.size() == 0) begin
            count_errs++;
            $display("%s: extra request from the DUT, code %h x %h vsub %h",
                     test_name, out_tile.code, out_tile.x, out_tile.vsub);
        end else begin
            e = exp_q.pop_front();
            if (out_tile !== e) begin
                value_errs++;
                $display("Fail %s: expected code %h x %h vsub %h, actual code %h x %h vsub %h",
                         test_name, e.code, e.x, e.vsub,
                         out_tile.code, out_tile.x, out_tile.vsub);
            end
        end
    endtask

    task automatic tick();
        @(negedge clk);
        cen        = ($urandom % 4) != 0;         // about 3/4 enabled
        wr         = 1'b0;
        line_start = 1'b0;
        pop        = 1'b0;
        if (!started && (out_valid || line_done)) begin
            proto_errs++;
            $display("out_valid or line_done went high before the first line start");
        end
        if (hold > 0) begin
            hold--;
        end else if (stalls_on && ($urandom % 24) == 0) begin
            hold = 1 + int'($urandom % 48);       // long enough to fill both queues
        end else if (out_valid && ($urandom % 4) != 0) begin
            take_head();                          // head is stable at the falling edge
            pop = 1'b1;
        end
    endtask

    task automatic write_entry(input logic [`OBJ_AW-1:0] a, input obj_entry_t o);
        tick();
        wr        = 1'b1;
        addr      = a;
        wdata     = o;
        mirror[a] = o;
    endtask

    task automatic run_line(input logic [8:0] line);
        int got_done;
        build_expected(line);
        tick();
        line_start = 1'b1;
        vrender    = line;
        started    = 1'b1;
        got_done   = 0;
        while (got_done == 0) begin
            tick();
            if (line_done) got_done = 1;
        end
        if (exp_q.size() > `TILE_DEPTH) begin     // more than the queue can hold
            proto_errs++;
            $display("%s: line_done came with %0d requests still unsent",
                     test_name, exp_q.size());
        end
        while (out_valid) begin
            tick();
        end
        if (exp_q.size() != 0) begin
            count_errs += exp_q.size();
            $display("%s: line %0d ended with %0d expected requests missing",
                     test_name, line, exp_q.size());
            exp_q.delete();
        end
    endtask

    // ============================================================
    // main sequence
    // ============================================================
    initial begin
        void'($urandom(91735));
        rst        = 1'b1;
        cen        = 1'b0;
        wr         = 1'b0;
        addr       = '0;
        wdata      = '0;
        line_start = 1'b0;
        vrender    = '0;
        pop        = 1'b0;
        value_errs = 0;
        count_errs = 0;
        proto_errs = 0;
        cycles     = 0;
        hold       = 0;
        stalls_on  = 1'b0;
        started    = 1'b0;
        test_name  = "reset";
        repeat (10) tick();
        rst = 1'b0;
        repeat (8) tick();                        // idle outputs stay low

        for (int k = 0; k < NUM_LINES; k++) begin
            phase = k / 4;
            case (phase)
                0:       test_name = "random_lines";
                1:       test_name = "vflip_code_wrap";
                2:       test_name = "low_zone";
                default: test_name = "back_pressure";
            endcase
            stalls_on = (phase == 3);
            vline     = (phase == 2) ? 9'(256 + $urandom % 256) : 9'($urandom % 256);
            nwrite    = (k == 0) ? `OBJ_COUNT : 1 + int'($urandom % `OBJ_COUNT);
            for (int i = 0; i < nwrite; i++) begin  // rewrites land before this line only
                wr_idx = (k == 0) ? `OBJ_AW'(i) : `OBJ_AW'($urandom);
                write_entry(wr_idx, rand_entry(vline, phase));
            end
            run_line(vline);
        end

        $display("errors: %0d value, %0d count, %0d protocol, %0d assertion",
                 value_errs, count_errs, proto_errs, dut.u_chk.fail_count);
        if (value_errs + count_errs + proto_errs + dut.u_chk.fail_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- src/obj_col_expander.sv
`timescale 1ns/1ns

module obj_col_expander
    import obj_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,

    // entry queue side
    input  obj_entry_t  entry,      // head of the entry queue
    input  logic        empty,
    output logic        pop,

    // request queue side
    input  logic        out_full,
    output logic        push,
    output obj_tile_t   tile,

    // tile match inputs
    output logic [15:0] m_code,
    output logic [3:0]  m_n,
    output logic [3:0]  m_tile_n,
    output logic [3:0]  m_tile_m,
    output logic        m_vflip,
    output logic [9:0]  m_y,

    // tile match results
    input  logic        inzone,
    input  logic [3:0]  vsub,
    input  logic [15:0] code_mn,

    output logic        active      // entry loaded or result in flight
);

    obj_entry_t cur;                // entry being expanded
    logic       loaded;             // cur still has columns to issue
    logic       pending;            // match output holds a valid column
    logic [3:0] col;                // next column to issue
    logic [3:0] p_n;                // column of the pending result
    logic [8:0] x_col;              // screen x of col
    logic [8:0] p_x;                // screen x of the pending result
    logic       stall;
    logic       drop;
    logic       issue;

    // ============================================================
    // control decode
    // ============================================================
    assign stall  = pending & inzone & out_full;           // no room for result
    assign drop   = pending & ~inzone & (p_n == 4'd0);     // whole object misses
    assign issue  = loaded & ~drop;                        // col goes to the match
    assign push   = cen & pending & inzone & ~out_full;
    assign pop    = cen & ~loaded & ~empty & ~stall;
    assign active = loaded | pending;

    assign tile.code = code_mn;
    assign tile.x    = p_x;                                // x travels with result
    assign tile.vsub = vsub;

    // while stalled the match sees the pending column again
    assign m_code   = cur.code;
    assign m_n      = stall ? p_n : col;
    assign m_tile_n = cur.tile_n;
    assign m_tile_m = cur.tile_m;
    assign m_vflip  = cur.vflip;
    assign m_y      = cur.y;

    // ============================================================
    // column state machine
    // ============================================================
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            loaded  <= 1'b0;
            pending <= 1'b0;
            col     <= '0;
            p_n     <= '0;
        end else if (cen && !stall) begin
            pending <= issue;                      // result lands next cen
            if (issue) begin
                p_n <= col;
                if (col == cur.tile_n) begin
                    loaded <= 1'b0;                // last column issued
                end else begin
                    col <= col + 1'b1;
                end
            end else if (loaded) begin
                loaded <= 1'b0;                    // early drop, skip the rest
            end else if (pop) begin
                loaded <= 1'b1;
                col    <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cen && !stall) begin
            if (issue) begin
                p_x   <= x_col;
                x_col <= x_col + 9'd16;            // wraps in 9 bits
            end else if (pop) begin
                cur   <= entry;
                x_col <= entry.x;
            end
        end
    end

endmodule

//--- src/obj_line_scan.sv
`timescale 1ns/1ns

`include "obj_settings.svh"

module obj_line_scan
    import obj_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               cen,
    input  logic               wr,
    input  logic [`OBJ_AW-1:0] addr,
    input  obj_entry_t         wdata,
    input  logic               line_start,
    input  logic [8:0]         vrender,
    input  logic               pop,          // consumer takes the head
    output logic               out_valid,
    output obj_tile_t          out_tile,
    output logic               line_done     // one-cycle end of scan
);

    logic [8:0]  vrender_q;
    logic        busy;
    logic        ent_push, ent_pop, ent_full, ent_empty;
    obj_entry_t  ent_din, ent_dout;
    logic        tile_push, tile_full, tile_empty;
    obj_tile_t   tile_din;
    logic [15:0] m_code, code_mn;
    logic [3:0]  m_n, m_tile_n, m_tile_m, vsub;
    logic        m_vflip, inzone, exp_active;
    logic [9:0]  m_y;
    logic        idle, idle_q;

    // ============================================================
    // datapath
    // ============================================================
    obj_table_reader u_reader (
        .clk, .rst, .cen, .wr, .addr, .wdata, .line_start, .vrender,
        .vrender_q, .push(ent_push), .entry(ent_din), .full(ent_full), .busy);

    obj_queue #(.DEPTH(`ENTRY_DEPTH), .payload_t(obj_entry_t)) u_entry_q (
        .clk, .rst, .push(ent_push), .din(ent_din), .pop(ent_pop),
        .dout(ent_dout), .full(ent_full), .empty(ent_empty));

    obj_col_expander u_expander (
        .clk, .rst, .cen, .entry(ent_dout), .empty(ent_empty), .pop(ent_pop),
        .out_full(tile_full), .push(tile_push), .tile(tile_din),
        .m_code, .m_n, .m_tile_n, .m_tile_m, .m_vflip, .m_y,
        .inzone, .vsub, .code_mn, .active(exp_active));

    obj_tile_match u_match (
        .clk, .rst, .cen, .obj_code(m_code), .tile_n(m_tile_n), .tile_m(m_tile_m),
        .n(m_n), .vflip(m_vflip), .vrenderf(vrender_q), .obj_y(m_y),
        .vsub, .inzone, .code_mn);

    obj_queue #(.DEPTH(`TILE_DEPTH), .payload_t(obj_tile_t)) u_tile_q (
        .clk, .rst, .push(tile_push), .din(tile_din), .pop,
        .dout(out_tile), .full(tile_full), .empty(tile_empty));

    assign out_valid = ~tile_empty;

    // ============================================================
    // end of line detect
    // ============================================================
    assign idle = ~busy & ent_empty & ~exp_active;   // nothing left upstream

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            idle_q <= 1'b1;                          // no pulse out of reset
        end else begin
            idle_q <= idle;
        end
    end

    assign line_done = idle & ~idle_q;               // rising edge of idle

endmodule

//--- src/obj_pkg.sv
package obj_pkg;

    // ============================================================
    // shared object types
    // ============================================================

    // signed-ish vertical position, line numbers compared in 10 bits
    typedef logic [9:0] obj_ypos_t;

    // one object table entry as written by the cpu
    typedef struct packed {
        logic [15:0] code;      // base tile code
        obj_ypos_t   y;         // top line of the object
        logic [8:0]  x;         // left pixel of column 0
        logic [3:0]  tile_n;    // extra tile columns, 0 means one column
        logic [3:0]  tile_m;    // extra tile rows, 0 means one row
        logic        vflip;     // vertical flip of the whole object
    } obj_entry_t;

    // one draw request handed to the pixel fetch side
    typedef struct packed {
        logic [15:0] code;      // tile code with row and column folded in
        logic [8:0]  x;         // screen x of this tile column
        logic [3:0]  vsub;      // line inside the 16-line tile
    } obj_tile_t;

endpackage

//--- src/obj_queue.sv
`timescale 1ns/1ns

module obj_queue #(
    parameter int  DEPTH     = 4,           // number of slots
    parameter type payload_t = logic [7:0]  // stored item
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push,      // write din at the tail
    input  payload_t din,
    input  logic     pop,       // drop the head
    output payload_t dout,      // head of the queue
    output logic     full,
    output logic     empty
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;  // pointer width
    localparam int CW = $clog2(DEPTH + 1);                // count width

    payload_t      mem [DEPTH];             // storage, no reset
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;                   // items held
    logic          do_push;
    logic          do_pop;

    // pointer step with wrap, depth need not be a power of two
    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] p);
        return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full    = (count == CW'(DEPTH));
    assign empty   = (count == '0);
    assign do_push = push & ~full;          // guard, callers check full anyway
    assign do_pop  = pop & ~empty;
    assign dout    = mem[rd_ptr];           // show-ahead head

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)  rd_ptr <= next_ptr(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // both or none, level unchanged
            endcase
        end
    end

endmodule

//--- src/obj_settings.svh
`ifndef OBJ_SETTINGS_SVH
`define OBJ_SETTINGS_SVH

// ============================================================
// object table geometry
// ============================================================
`define OBJ_COUNT   16          // entries in the object table
`define OBJ_AW      4           // table address width, log2 of OBJ_COUNT

// ============================================================
// queue depths
// ============================================================
`define ENTRY_DEPTH 4           // entries waiting for the column expander
`define TILE_DEPTH  8           // draw requests waiting for the consumer

`endif

//--- src/obj_table_reader.sv
`timescale 1ns/1ns

`include "obj_settings.svh"

module obj_table_reader
    import obj_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               cen,        // pixel clock enable

    // cpu side
    input  logic               wr,         // table write strobe
    input  logic [`OBJ_AW-1:0] addr,       // entry index
    input  obj_entry_t         wdata,      // entry contents

    // scan control
    input  logic               line_start, // start walking the table
    input  logic [8:0]         vrender,    // line to render
    output logic [8:0]         vrender_q,  // latched line, held as a level

    // entry queue side
    output logic               push,       // push one entry
    output obj_entry_t         entry,      // entry being pushed
    input  logic               full,       // entry queue has no room
    output logic               busy        // scan still walking the table
);

    // ============================================================
    // object table
    // ============================================================
    obj_entry_t         tbl [`OBJ_COUNT];  // register array, no reset
    logic [`OBJ_AW-1:0] idx;               // scan position

    // cpu writes land on the next edge, cen plays no part here
    always_ff @(posedge clk) begin
        if (wr) begin
            tbl[addr] <= wdata;
        end
    end

    // ============================================================
    // scan walker
    // ============================================================
    assign push  = busy & cen & ~full;     // hold index while queue is full
    assign entry = tbl[idx];               // head of the scan, read async

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            busy      <= 1'b0;
            idx       <= '0;
            vrender_q <= '0;
        end else if (line_start) begin     // restarts a scan in flight too
            busy      <= 1'b1;
            idx       <= '0;
            vrender_q <= vrender;          // kept for the whole line
        end else if (push) begin
            idx <= idx + 1'b1;             // walk in index order
            if (idx == `OBJ_AW'(`OBJ_COUNT - 1)) begin
                busy <= 1'b0;              // last entry is on its way
            end
        end
    end

endmodule

//--- src/obj_tile_match.sv
`timescale 1ns/1ns

module obj_tile_match
    import obj_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,

    input  logic [15:0] obj_code,   // base code of the object
    input  logic [3:0]  tile_n,     // extra columns
    input  logic [3:0]  tile_m,     // extra rows
    input  logic [3:0]  n,          // column being tested
    input  logic        vflip,
    input  logic [8:0]  vrenderf,   // render line
    input  obj_ypos_t   obj_y,      // object top line

    output logic [3:0]  vsub,       // line inside the tile
    output logic        inzone,     // object covers the line
    output logic [15:0] code_mn     // code with row and column added
);

    obj_ypos_t  vs;                 // line sign-extended to 10 bits
    obj_ypos_t  bottom;             // first line below the object
    obj_ypos_t  ycross;             // distance from the object top
    logic [8:0] vd;                 // same distance in 9 bits, for vsub
    logic [3:0] row;                // tile row, after flip

    // ============================================================
    // zone and row arithmetic
    // ============================================================
    always_comb begin
        vs       = {vrenderf[8], vrenderf};
        bottom   = obj_y + {2'd0, tile_m, 4'd0} + 10'h10;  // y + 16*(m+1)
        ycross   = vs - obj_y;
        vd       = vrenderf - obj_y[8:0];
        row      = vflip ? tile_m - ycross[7:4] : ycross[7:4];
    end

    // ============================================================
    // registered results, one cen cycle behind the inputs
    // ============================================================
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            inzone  <= 1'b0;
            vsub    <= '0;
            code_mn <= '0;
        end else if (cen) begin
            // same answer for every column of the object
            inzone  <= (bottom > vs) && (vs >= obj_y);
            vsub    <= vd[3:0] ^ {4{vflip}};             // flipped rows count down
            code_mn <= obj_code + {8'd0, row, n};        // 16-bit sum, carries out
        end
    end

endmodule

//--- tb.f
+incdir+src
src/obj_pkg.sv
src/obj_queue.sv
src/obj_table_reader.sv
src/obj_tile_match.sv
src/obj_col_expander.sv
src/obj_line_scan.sv
sim/obj_line_scan_chk.sv
sim/obj_line_scan_tb.sv
